// ==== rtl/mcu_pkg.sv ====
//******************************
// MCU peripheral constants
// Memory map and I/O register
// addresses of the 63701 shell
//******************************

`default_nettype none

package mcu_pkg;

    // Internal RAM window, 256 bytes
    localparam logic [15:0] ram_base = 16'h0040;
    localparam logic [15:0] ram_end  = 16'h013F;

    // Size of the I/O register file
    localparam int port_regs = 32;

    // Data-direction registers for ports 1 to 4
    // Entry 0 belongs to port 1
    localparam logic [3:0][4:0] ddr_addr = {
        5'd5,
        5'd4,
        5'd1,
        5'd0
    };

    // Port data (output latch) registers for ports 1 to 4
    localparam logic [3:0][4:0] data_addr = {
        5'd7,
        5'd6,
        5'd3,
        5'd2
    };

endpackage

`default_nettype wire

// ==== rtl/cpu_bus_if.sv ====
//******************************
// CPU bus interface
// Address, data, strobes and the
// decoded region selects
//******************************

`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if (
    input logic clk
);
    // Synchronous reset for the register file
    logic        rst;

    // Raw CPU bus
    logic [15:0] addr;
    logic [7:0]  wr_data;
    logic        wrn;
    logic        vma;
    logic        cen_cpu;
    logic [7:0]  rd_data;

    // Region selects
    logic        port_cs;
    logic        ram_cs;
    logic        rom_cs;
    logic        bus_free;

    modport decoder (
        input  clk, addr, vma,
        output port_cs, ram_cs, rom_cs, bus_free, rd_data
    );

    modport ports (
        input  clk, rst, addr, wr_data, wrn, cen_cpu, port_cs
    );

    modport ram (
        input  clk, addr, wr_data, wrn, cen_cpu, ram_cs
    );

    modport gate (
        input  rom_cs, bus_free
    );

endinterface

`default_nettype wire

// ==== rtl/mcu_addr_decode.sv ====
//******************************
// Address decoder
// Splits the CPU space into I/O,
// RAM and ROM, muxes read data
//******************************

`timescale 1ns/1ps
`default_nettype none

module mcu_addr_decode
    import mcu_pkg::*;
#(
    parameter int rom_w    = 12,
    parameter int max_port = 27
) (
    cpu_bus_if.decoder bus,
    input  logic       ext_cs,
    input  logic [7:0] ext_data,
    input  logic [7:0] io_q,
    input  logic [7:0] ram_q,
    input  logic [7:0] rom_data
);

    logic port_hit;
    logic ram_hit;
    logic rom_hit;

    // Register file sits at the bottom of the map
    assign port_hit = bus.addr <= 16'(max_port);

    // Internal RAM window
    assign ram_hit = (bus.addr >= ram_base) && (bus.addr <= ram_end);

    // ROM fills the top, all upper bits set
    assign rom_hit = &bus.addr[15:rom_w];

    // Selects only count on a valid memory access
    assign bus.port_cs = bus.vma && port_hit;
    assign bus.ram_cs  = bus.vma && ram_hit;
    assign bus.rom_cs  = bus.vma && rom_hit;

    // Nothing internal claims the bus
    // Used by the enable gate to replay lost pulses
    assign bus.bus_free = !bus.port_cs && !bus.ram_cs && !bus.rom_cs;

    // Read mux
    // RAM wins over the external window, which wins over I/O
    always_comb begin
        if (bus.ram_cs) begin
            bus.rd_data = ram_q;
        end else if (ext_cs) begin
            bus.rd_data = ext_data;
        end else if (bus.port_cs) begin
            bus.rd_data = io_q;
        end else begin
            // ROM is the fallback source
            bus.rd_data = rom_data;
        end
    end

    // Regions must stay disjoint for any parameter choice
    a_cs_disjoint: assert property (
        @(posedge bus.clk)
        $onehot0({bus.port_cs, bus.ram_cs, bus.rom_cs})
    ) else $error("decoder: overlapping selects at addr %h", bus.addr);

endmodule

`default_nettype wire

// ==== rtl/mcu_io_ports.sv ====
//******************************
// I/O register file
// Four 8-bit ports with direction
// registers and masked pin reads
//******************************

`timescale 1ns/1ps
`default_nettype none

module mcu_io_ports
    import mcu_pkg::*;
#(
    parameter int max_port = 27
) (
    cpu_bus_if.ports         bus,
    input  logic [3:0][7:0]  p_in,
    output logic [3:0][7:0]  p_out,
    output logic [7:0]       io_q
);

    logic [7:0]      regs [port_regs];
    logic [3:0][7:0] ddr;
    logic [4:0]      reg_sel;
    logic            we;

    // Five address bits index the 32 entries
    assign reg_sel = bus.addr[4:0];

    // Write strobe, one per CPU enable
    assign we = bus.cen_cpu && bus.port_cs && !bus.wrn;

    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            // All pins come up as inputs, latches at zero
            for (int i = 0; i < port_regs; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (we) begin
            regs[reg_sel] <= bus.wr_data;
        end
    end

    // Output latches and direction bits per port
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            p_out[i] = regs[data_addr[i]];
            ddr[i]   = regs[ddr_addr[i]];
        end
    end

    // Register read
    // Data addresses mix latch and pin bit by bit
    always_comb begin
        io_q = regs[reg_sel];
        for (int i = 0; i < 4; i++) begin
            if (reg_sel == data_addr[i]) begin
                // Direction 1 means output, read back the latch
                io_q = (p_out[i] & ddr[i]) | (p_in[i] & ~ddr[i]);
            end
        end
    end

    // Decoder must keep writes inside the decoded register range
    a_no_write_above_max: assert property (
        @(posedge bus.clk) disable iff (bus.rst)
        we |-> (bus.addr <= 16'(max_port))
    ) else $error("io_ports: write to addr %h above max_port", bus.addr);

endmodule

`default_nettype wire

// ==== rtl/mcu_int_ram.sv ====
//******************************
// Internal RAM
// 256 x 8 with registered read
//******************************

`timescale 1ns/1ps
`default_nettype none

module mcu_int_ram
    import mcu_pkg::*;
(
    cpu_bus_if.ram     bus,
    output logic [7:0] ram_q
);

    logic [7:0] mem [256];
    logic [7:0] idx;
    logic       we;

    // Offset into the window, low byte is enough
    assign idx = 8'(bus.addr - ram_base);

    // Write strobe
    assign we = bus.cen_cpu && bus.ram_cs && !bus.wrn;

    always_ff @(posedge bus.clk) begin
        if (we) begin
            mem[idx] <= bus.wr_data;
        end
    end

    // Read updates on every clk, ahead of the next CPU enable
    always_ff @(posedge bus.clk) begin
        ram_q <= mem[idx];
    end

endmodule

`default_nettype wire

// ==== rtl/mcu_rom_wait.sv ====
//******************************
// ROM wait gate
// Stalls the CPU enable on ROM
// misses, replays lost pulses
//******************************

`timescale 1ns/1ps
`default_nettype none

module mcu_rom_wait (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    start,
    input  logic    rom_ok,
    cpu_bus_if.gate bus,
    output logic    cen_cpu
);

    logic       started;
    logic [3:0] pending;
    logic       stall;
    logic       sat;
    logic       pass;
    logic       lost;
    logic       replay;

    // ROM selected but data not there yet
    assign stall = bus.rom_cs && !rom_ok;

    // Counter is full, further pulses cannot be tracked
    assign sat = &pending;

    // Normal path, raw enable goes straight through
    assign pass = started && !stall && !sat;

    // Pulse swallowed by a stall
    assign lost = started && cen && stall && !sat;

    // Catch-up slot, raw enable low and nothing internal on the bus
    assign replay = started && !cen && bus.bus_free && (pending != 4'd0);

    assign cen_cpu = (cen && pass) || replay;

    // Hold off the CPU until the loader says go
    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    // Lost pulse count
    // lost needs cen high, replay needs it low
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 4'd0;
        end else if (lost) begin
            pending <= pending + 4'd1;
        end else if (replay) begin
            pending <= pending - 4'd1;
        end
    end

    // CPU must never sample the ROM before the data is valid
    a_no_cen_on_miss: assert property (
        @(posedge clk) disable iff (rst)
        !(cen_cpu && bus.rom_cs && !rom_ok)
    ) else $error("rom_wait: cen_cpu during ROM miss");

endmodule

`default_nettype wire

// ==== rtl/mcu_periph_top.sv ====
//******************************
// 63701 peripheral shell
// Bus decode, I/O ports, internal
// RAM and ROM wait gating
//******************************

`timescale 1ns/1ps
`default_nettype none

module mcu_periph_top #(
    parameter int rom_w    = 12,
    parameter int max_port = 27
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic             start,
    // CPU bus
    input  logic             vma,
    input  logic             wrn,
    input  logic [15:0]      addr,
    input  logic [7:0]       cpu_dout,
    output logic [7:0]       cpu_din,
    output logic             cen_cpu,
    // External data window
    input  logic             ext_cs,
    input  logic [7:0]       ext_dout,
    // Program ROM
    output logic             rom_cs,
    output logic [rom_w-1:0] rom_addr,
    input  logic [7:0]       rom_data,
    input  logic             rom_ok,
    // Ports
    input  logic [7:0]       p1_in,
    input  logic [7:0]       p2_in,
    input  logic [7:0]       p3_in,
    input  logic [7:0]       p4_in,
    output logic [7:0]       p1_out,
    output logic [7:0]       p2_out,
    output logic [7:0]       p3_out,
    output logic [7:0]       p4_out
);

    logic [3:0][7:0] p_in;
    logic [3:0][7:0] p_out;
    logic [7:0]      io_q;
    logic [7:0]      ram_q;

    cpu_bus_if bus (.clk(clk));

    // Plain ports onto the internal bus
    assign bus.rst     = rst;
    assign bus.addr    = addr;
    assign bus.wr_data = cpu_dout;
    assign bus.wrn     = wrn;
    assign bus.vma     = vma;
    assign bus.cen_cpu = cen_cpu;

    assign cpu_din  = bus.rd_data;
    assign rom_cs   = bus.rom_cs;
    // ROM sees the low address bits only
    assign rom_addr = addr[rom_w-1:0];

    // Port 1 in the lowest byte
    assign p_in   = {p4_in, p3_in, p2_in, p1_in};
    assign p1_out = p_out[0];
    assign p2_out = p_out[1];
    assign p3_out = p_out[2];
    assign p4_out = p_out[3];

    mcu_addr_decode #(
        .rom_w    (rom_w),
        .max_port (max_port)
    ) u_decode (
        .bus      (bus),
        .ext_cs   (ext_cs),
        .ext_data (ext_dout),
        .io_q     (io_q),
        .ram_q    (ram_q),
        .rom_data (rom_data)
    );

    mcu_io_ports #(
        .max_port (max_port)
    ) u_ports (
        .bus   (bus),
        .p_in  (p_in),
        .p_out (p_out),
        .io_q  (io_q)
    );

    mcu_int_ram u_ram (
        .bus   (bus),
        .ram_q (ram_q)
    );

    mcu_rom_wait u_wait (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .start   (start),
        .rom_ok  (rom_ok),
        .bus     (bus),
        .cen_cpu (cen_cpu)
    );

endmodule

`default_nettype wire

// ==== verification/tb_mcu_periph.sv ====
//******************************
// Testbench for the 63701 shell
// Plays the CPU and the ROM, and
// checks ports, RAM, windows, cen
//******************************

`timescale 1ns/1ps
`default_nettype none

module tb_mcu_periph;

    localparam int clk_half      = 10;
    localparam int watchdog_clks = 4000;

    logic        clk;
    logic        rst;
    logic        cen = 1'b0;
    logic        start;
    logic        vma;
    logic        wrn;
    logic [15:0] addr;
    logic [7:0]  cpu_dout;
    logic [7:0]  cpu_din;
    logic        cen_cpu;
    logic        ext_cs;
    logic [7:0]  ext_dout;
    logic        rom_cs;
    logic [11:0] rom_addr;
    logic [7:0]  rom_data;
    logic        rom_ok;
    logic [7:0]  p1_in;
    logic [7:0]  p2_in;
    logic [7:0]  p3_in;
    logic [7:0]  p4_in;
    logic [7:0]  p1_out;
    logic [7:0]  p2_out;
    logic [7:0]  p3_out;
    logic [7:0]  p4_out;

    // Reference state
    logic [7:0]  reg_m [32];
    logic [7:0]  ram_m [256];
    logic [11:0] rom_last;
    int          rom_delay;
    logic        started_m = 1'b0;
    int          cen_pulses = 0;
    int          cpu_pulses = 0;
    int          errors = 0;

    mcu_periph_top dut0 (
        .clk(clk), .rst(rst), .cen(cen), .start(start),
        .vma(vma), .wrn(wrn), .addr(addr), .cpu_dout(cpu_dout),
        .cpu_din(cpu_din), .cen_cpu(cen_cpu),
        .ext_cs(ext_cs), .ext_dout(ext_dout),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .p1_in(p1_in), .p2_in(p2_in), .p3_in(p3_in), .p4_in(p4_in),
        .p1_out(p1_out), .p2_out(p2_out), .p3_out(p3_out), .p4_out(p4_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    // Raw enable high on every second clk
    always @(negedge clk) begin
        cen <= !cen;
    end

    // Pulse counters sampled at the DUT's clock edge
    always @(posedge clk) begin
        if (started_m && cen) cen_pulses++;
        if (cen_cpu) cpu_pulses++;
        if (!rst && start) started_m <= 1'b1;
    end

    a_no_cen_on_miss: assert property (
        @(posedge clk) disable iff (rst) !(cen_cpu && rom_cs && !rom_ok)
    ) else begin
        errors++;
        $display("Fail %0t: cen_cpu high during a ROM stall", $time);
    end

    // ROM select only for the top 4 KB
    a_rom_cs_map: assert property (
        @(posedge clk) disable iff (rst) rom_cs == (vma && (addr[15:12] == 4'hf))
    ) else begin
        errors++;
        $display("Fail %0t: rom_cs %b at addr %h", $time, rom_cs, addr);
    end

    // ROM address is the low 12 bits of the CPU address
    a_rom_addr_map: assert property (
        @(posedge clk) rom_addr == addr[11:0]
    ) else begin
        errors++;
        $display("Fail %0t: rom_addr %h at addr %h", $time, rom_addr, addr);
    end

    a_no_cen_before_start: assert property (
        @(posedge clk) disable iff (rst) !started_m |-> !cen_cpu
    ) else begin
        errors++;
        $display("Fail %0t: cen_cpu before start", $time);
    end

    initial begin
        repeat (watchdog_clks) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_clks);
        $display("Errors: %0d", errors);
        $display("TEST FAIL");
        $finish;
    end

    // ROM byte depends on all 12 address bits
    function automatic logic [7:0] rom_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    // Port data reads mix latch and pin by direction bit
    function automatic logic [7:0] port_read_model(input logic [4:0] a);
        logic [7:0] pin;
        logic [7:0] dir;
        case (a)
            5'd2: begin
                pin = p1_in;
                dir = reg_m[0];
            end
            5'd3: begin
                pin = p2_in;
                dir = reg_m[1];
            end
            5'd6: begin
                pin = p3_in;
                dir = reg_m[4];
            end
            5'd7: begin
                pin = p4_in;
                dir = reg_m[5];
            end
            default: return reg_m[a];
        endcase
        return (reg_m[a] & dir) | (pin & ~dir);
    endfunction

    task automatic expect_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Fail %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Called once per falling edge
    // rom_ok low for 0 to 6 clk after a new address
    task automatic step_rom_model();
        if (addr[11:0] != rom_last) begin
            rom_last  = addr[11:0];
            rom_delay = int'($urandom % 7);
        end
        if (rom_delay != 0) begin
            rom_ok = 1'b0;
            rom_delay--;
        end else begin
            rom_ok = 1'b1;
        end
        rom_data = rom_byte(addr[11:0]);
    endtask

    // One CPU access ending on the falling edge after its cen_cpu pulse
    task automatic bus_cycle(input logic v, input logic w_n, input logic [15:0] a,
                             input logic [7:0] d, output logic [7:0] q);
        logic hit;
        vma      = v;
        wrn      = w_n;
        addr     = a;
        cpu_dout = d;
        p1_in    = 8'($urandom);
        p2_in    = 8'($urandom);
        p3_in    = 8'($urandom);
        p4_in    = 8'($urandom);
        step_rom_model();
        hit = 1'b0;
        q   = 8'h00;
        while (!hit) begin
            @(posedge clk);
            hit = cen_cpu;
            q   = cpu_din;
            @(negedge clk);
            if (!hit) step_rom_model();
        end
    endtask

    task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] q;
        bus_cycle(1'b1, 1'b0, a, d, q);
    endtask

    task automatic read_byte(input logic [15:0] a, output logic [7:0] q);
        bus_cycle(1'b1, 1'b1, a, 8'h00, q);
    endtask

    task automatic idle_cycle();
        logic [7:0] q;
        bus_cycle(1'b0, 1'b1, addr, 8'h00, q);
    endtask

    initial begin
        logic [7:0]  d;
        logic [7:0]  q;
        logic [7:0]  ram_idx;
        logic [15:0] a16;
        void'($urandom(32'h3b1));
        rst       = 1'b1;
        start     = 1'b0;
        vma       = 1'b0;
        wrn       = 1'b1;
        addr      = 16'h0000;
        cpu_dout  = 8'h00;
        ext_cs    = 1'b0;
        ext_dout  = 8'h00;
        rom_data  = 8'h00;
        rom_ok    = 1'b1;
        rom_last  = 12'h000;
        rom_delay = 0;
        p1_in     = 8'h00;
        p2_in     = 8'h00;
        p3_in     = 8'h00;
        p4_in     = 8'h00;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Held off before start with latches cleared
        for (int i = 0; i < 10; i++) begin
            step_rom_model();
            @(negedge clk);
        end
        expect_byte("p1_out", p1_out, 8'h00);
        expect_byte("p2_out", p2_out, 8'h00);
        expect_byte("p3_out", p3_out, 8'h00);
        expect_byte("p4_out", p4_out, 8'h00);
        start = 1'b1;
        idle_cycle();

        // Two rounds of fresh values through the I/O register file
        for (int round = 0; round < 2; round++) begin
            for (int a = 0; a <= 27; a++) begin
                d = 8'($urandom);
                write_byte(16'(a), d);
                reg_m[5'(a)] = d;
            end
            expect_byte("p1_out", p1_out, reg_m[2]);
            expect_byte("p2_out", p2_out, reg_m[3]);
            expect_byte("p3_out", p3_out, reg_m[6]);
            expect_byte("p4_out", p4_out, reg_m[7]);
            for (int a = 0; a <= 27; a++) begin
                read_byte(16'(a), q);
                expect_byte("io register", q, port_read_model(5'(a)));
            end
        end

        // RAM fill then random mix of writes and reads
        for (int i = 0; i < 256; i++) begin
            d = 8'($urandom);
            write_byte(16'h0040 + 16'(i), d);
            ram_m[8'(i)] = d;
        end
        read_byte(16'h0040, q);
        expect_byte("ram first", q, ram_m[0]);
        read_byte(16'h013f, q);
        expect_byte("ram last", q, ram_m[255]);
        for (int i = 0; i < 200; i++) begin
            ram_idx = 8'($urandom);
            if ($urandom % 2 == 0) begin
                d = 8'($urandom);
                write_byte(16'h0040 + 16'(ram_idx), d);
                ram_m[ram_idx] = d;
            end else begin
                read_byte(16'h0040 + 16'(ram_idx), q);
                expect_byte("ram", q, ram_m[ram_idx]);
            end
        end

        // External window away from RAM and ROM
        for (int i = 0; i < 16; i++) begin
            a16      = 16'h0200 + 16'($urandom % 32'h6000);
            ext_cs   = 1'b1;
            ext_dout = 8'($urandom);
            read_byte(a16, q);
            expect_byte("external window", q, ext_dout);
        end
        ext_cs = 1'b0;

        // ROM reads with random stalls
        // Six idle cycles let the gate replay up to three lost pulses
        for (int i = 0; i < 16; i++) begin
            a16 = 16'hf000 | 16'($urandom % 32'h1000);
            read_byte(a16, q);
            expect_byte("rom", q, rom_byte(a16[11:0]));
            repeat (6) idle_cycle();
        end

        // Closing idle run drains anything still pending
        repeat (20) idle_cycle();
        assert (cpu_pulses == cen_pulses) else begin
            errors++;
            $display("Fail %0t: %0d cen_cpu pulses against %0d cen pulses",
                     $time, cpu_pulses, cen_pulses);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/mcu_pkg.sv
rtl/cpu_bus_if.sv
rtl/mcu_addr_decode.sv
rtl/mcu_io_ports.sv
rtl/mcu_int_ram.sv
rtl/mcu_rom_wait.sv
rtl/mcu_periph_top.sv
verification/tb_mcu_periph.sv

// ==== Makefile ====
# Verilator build and run for the 63701 peripheral shell testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu_periph
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

# The log decides pass or fail
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
